/* all.f */
logic/mem_test_pkg.sv
logic/test_csr.sv
logic/address_block.sv
logic/control_block.sv
logic/transmitter_block.sv
logic/compare_block.sv
logic/mem_tester_top.sv
verification/wb_mem_model.sv
verification/tb_mem_tester.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the memory tester testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 -f all.f --top-module tb_mem_tester \
  -o tb_mem_tester > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_mem_tester > sim.log 2>&1
if [ $? -ne 0 ]; then
  cat sim.log
  echo "Simulation exited with an error status"
  exit 1
fi

cat sim.log
if grep -q "Some tests failed" sim.log; then
  exit 1
fi
if ! grep -q "All tests passed" sim.log; then
  echo "Simulation ended without a result line"
  exit 1
fi
exit 0

/* verification/tb_mem_tester.sv */
`timescale 1ns/1ps

module tb_mem_tester;

  import mem_test_pkg::*;

  localparam int CLK_NS     = 100;
  localparam int MAX_DELAY  = 3;
  localparam int MAX_CMDS   = 32;
  localparam int NUM_TESTS  = 6;
  localparam int TEST_FIXED = 400;
  // Write-and-check and fault tests count two commands per word
  localparam int ALL_CMDS   = 7 * MAX_CMDS;
  localparam int WD_CYCLES  = (NUM_TESTS * TEST_FIXED + ALL_CMDS * 4) * (MAX_DELAY + 2);
  localparam int POLL_LIMIT = 2 * MAX_CMDS * (MAX_DELAY + 3) + 50;

  logic       clk_i;
  logic       rst_i;
  logic       wb_cyc;
  logic       wb_stb;
  logic       wb_we;
  csr_addr_t  wb_adr;
  data_t      wb_dat_w;
  data_t      wb_dat_r;
  logic       wb_ack;
  logic       mem_cyc;
  logic       mem_stb;
  logic       mem_we;
  addr_t      mem_adr;
  data_t      mem_dat_w;
  data_t      mem_dat_r;
  logic       mem_ack;
  logic       mem_clear;
  logic       preload_en;
  addr_t      preload_addr;
  logic [3:0] ack_delay;
  logic [3:0] fixed_delay;
  logic       rand_delay_en;
  logic       fault_en;
  addr_t      fault_addr;

  logic [31:0] rand_state;
  logic [31:0] delay_state;
  int          err_count;
  int          err_at_start;
  int          pass_tests;
  int          fail_tests;

  mem_tester_top DUT (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .wb_cyc_i  (wb_cyc),
    .wb_stb_i  (wb_stb),
    .wb_we_i   (wb_we),
    .wb_adr_i  (wb_adr),
    .wb_dat_i  (wb_dat_w),
    .wb_dat_o  (wb_dat_r),
    .wb_ack_o  (wb_ack),
    .mem_cyc_o (mem_cyc),
    .mem_stb_o (mem_stb),
    .mem_we_o  (mem_we),
    .mem_adr_o (mem_adr),
    .mem_dat_o (mem_dat_w),
    .mem_dat_i (mem_dat_r),
    .mem_ack_i (mem_ack)
  );

  wb_mem_model MEM (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .clear_i        (mem_clear),
    .preload_en_i   (preload_en),
    .preload_addr_i (preload_addr),
    .ack_delay_i    (ack_delay),
    .fault_en_i     (fault_en),
    .fault_addr_i   (fault_addr),
    .cyc_i          (mem_cyc),
    .stb_i          (mem_stb),
    .we_i           (mem_we),
    .adr_i          (mem_adr),
    .dat_i          (mem_dat_w),
    .dat_o          (mem_dat_r),
    .ack_o          (mem_ack)
  );

  initial
  begin
    clk_i = 1'b0;
    forever #(CLK_NS / 2) clk_i = ~clk_i;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function logic [31:0] next_rand();
    rand_state = lcg_next(rand_state);
    return {16'd0, rand_state[31:16]};
  endfunction

  // Memory ack delay is fixed or changes every cycle
  always @(posedge clk_i)
  begin
    delay_state = lcg_next(delay_state);
    if (rand_delay_en)
      ack_delay <= 4'(delay_state[31:16] % (MAX_DELAY + 1));
    else
      ack_delay <= fixed_delay;
  end

  task automatic check(input data_t got, input data_t exp, input string msg);
    if (got !== exp)
    begin
      $display("CHECK FAILED at %0t: %s (got %h, expected %h)", $time, msg, got, exp);
      err_count++;
    end
  endtask

  // Classic single cycles keep the strobe with the cycle signal
  always @(posedge clk_i)
  begin
    if (!rst_i)
      check(32'(mem_stb), 32'(mem_cyc), "memory strobe differs from the cycle signal");
  end

  task automatic host_write(input csr_addr_t a, input data_t d);
    @(posedge clk_i);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= 1'b1;
    wb_adr   <= a;
    wb_dat_w <= d;
    @(posedge clk_i);
    while (!wb_ack)
      @(posedge clk_i);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
  endtask

  task automatic host_read(input csr_addr_t a, output data_t d);
    @(posedge clk_i);
    wb_cyc <= 1'b1;
    wb_stb <= 1'b1;
    wb_we  <= 1'b0;
    wb_adr <= a;
    @(posedge clk_i);
    while (!wb_ack)
      @(posedge clk_i);
    d = wb_dat_r;
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
  endtask

  task automatic clear_model();
    @(posedge clk_i);
    mem_clear <= 1'b1;
    @(posedge clk_i);
    mem_clear <= 1'b0;
  endtask

  task automatic preload_words(input addr_t s, input int n);
    for (int i = 0; i < n; i++)
    begin
      @(posedge clk_i);
      preload_en   <= 1'b1;
      preload_addr <= s + addr_t'(i);
    end
    @(posedge clk_i);
    preload_en <= 1'b0;
  endtask

  // Program one test, start it and poll the status register
  task automatic start_and_wait(input count_t n, input logic [1:0] mode, input addr_t s,
                                input int limit, output logic fin, output logic err);
    data_t st;
    host_write(CSR_TEST_PARAM, {n, mode, 14'd0});
    host_write(CSR_SET_ADDR, data_t'(s));
    host_write(CSR_CTRL, 32'd1);
    fin = 1'b0;
    err = 1'b0;
    for (int i = 0; i < limit; i++)
    begin
      host_read(CSR_CTRL, st);
      fin = st[0];
      err = st[1];
      if (fin)
        break;
    end
  endtask

  task automatic begin_test();
    err_at_start = err_count;
    clear_model();
  endtask

  task automatic end_test(input string name);
    if (err_count == err_at_start)
    begin
      pass_tests++;
      $display("PASS %s", name);
    end
    else
    begin
      fail_tests++;
      $display("FAIL %s", name);
    end
  endtask

  task automatic test_csr_rw();
    data_t p;
    data_t a;
    data_t rd;
    data_t hi;
    data_t lo;
    begin_test();
    hi = next_rand();
    lo = next_rand();
    p  = {hi[15:0], lo[15:0]};
    hi = next_rand();
    lo = next_rand();
    a  = {hi[15:0], lo[15:0]};
    host_write(CSR_TEST_PARAM, p);
    host_write(CSR_SET_ADDR, a);
    host_read(CSR_TEST_PARAM, rd);
    check(rd, p, "test parameter register readback");
    host_read(CSR_SET_ADDR, rd);
    check(rd, a, "start address register readback");
    end_test("csr access");
  endtask

  task automatic test_write_only();
    addr_t s;
    int    n;
    logic  fin;
    logic  err;
    begin_test();
    s = addr_t'(next_rand() % 32'hff00);
    n = int'(next_rand() % MAX_CMDS) + 1;
    fixed_delay <= 4'd1;
    start_and_wait(count_t'(n), 2'd0, s, POLL_LIMIT, fin, err);
    check(32'(fin), 32'd1, "write-only finished");
    check(32'(err), 32'd0, "write-only error bit");
    check(32'(MEM.wr_cnt), 32'(n), "write-only write count");
    check(32'(MEM.rd_cnt), 32'd0, "write-only read count");
    for (int i = 0; i < n; i++)
      check(MEM.mem[s + addr_t'(i)], data_t'(s + addr_t'(i)), "write-only memory word");
    end_test("write-only");
  endtask

  task automatic test_read_only();
    addr_t s;
    int    n;
    logic  fin;
    logic  err;
    begin_test();
    s = addr_t'(next_rand() % 32'hff00);
    n = int'(next_rand() % MAX_CMDS) + 1;
    preload_words(s, n);
    fixed_delay <= 4'd2;
    start_and_wait(count_t'(n), 2'd1, s, POLL_LIMIT, fin, err);
    check(32'(fin), 32'd1, "read-only finished");
    check(32'(err), 32'd0, "read-only error bit");
    check(32'(MEM.rd_cnt), 32'(n), "read-only read count");
    check(32'(MEM.wr_cnt), 32'd0, "read-only write count");
    end_test("read-only");
  endtask

  task automatic test_write_check();
    addr_t s;
    int    n;
    logic  fin;
    logic  err;
    begin_test();
    s = addr_t'(next_rand() % 32'hff00);
    n = int'(next_rand() % MAX_CMDS) + 1;
    rand_delay_en <= 1'b1;
    start_and_wait(count_t'(n), 2'd2, s, POLL_LIMIT, fin, err);
    rand_delay_en <= 1'b0;
    check(32'(fin), 32'd1, "write-and-check finished");
    check(32'(err), 32'd0, "write-and-check error bit");
    check(32'(MEM.wr_cnt), 32'(n), "write-and-check write count");
    check(32'(MEM.rd_cnt), 32'(n), "write-and-check read count");
    for (int i = 0; i < n; i++)
    begin
      check(32'(MEM.op_we[2*i]), 32'd1, "write comes first for the address");
      check(32'(MEM.op_adr[2*i]), 32'(s + addr_t'(i)), "write address");
      check(32'(MEM.op_we[2*i+1]), 32'd0, "read follows the write");
      check(32'(MEM.op_adr[2*i+1]), 32'(s + addr_t'(i)), "read address");
    end
    end_test("write-and-check");
  endtask

  task automatic test_fault();
    addr_t s;
    int    n;
    int    k;
    logic  fin;
    logic  err;
    begin_test();
    s = addr_t'(next_rand() % 32'hff00);
    n = int'(next_rand() % 8) + 8;
    k = int'(next_rand() % 32'(n));
    fault_addr  <= s + addr_t'(k);
    fault_en    <= 1'b1;
    fixed_delay <= 4'd0;
    start_and_wait(count_t'(n), 2'd2, s, POLL_LIMIT, fin, err);
    fault_en <= 1'b0;
    check(32'(fin), 32'd1, "fault test finished");
    check(32'(err), 32'd1, "fault test error bit");
    check(32'(MEM.op_cnt), 32'(2 * (k + 1)), "commands stop at the faulty address");
    for (int i = 0; i < MEM.op_cnt && i < 256; i++)
      if (MEM.op_adr[i] > fault_addr)
        check(32'(MEM.op_adr[i]), 32'(fault_addr), "command beyond the faulty address");
    end_test("fault injection");
  endtask

  task automatic test_edge_params();
    addr_t s;
    logic  fin;
    logic  err;
    begin_test();
    s = addr_t'(next_rand() % 32'hff00);
    fixed_delay <= 4'd1;
    start_and_wait(count_t'(0), 2'd0, s, POLL_LIMIT, fin, err);
    check(32'(fin), 32'd1, "count zero finished");
    check(32'(MEM.op_cnt), 32'd1, "count zero issues one command");
    clear_model();
    // Reserved mode must never finish, so a short poll is enough
    start_and_wait(count_t'(4), 2'd3, s, 20, fin, err);
    check(32'(fin), 32'd0, "invalid mode leaves finished low");
    check(32'(MEM.op_cnt), 32'd0, "invalid mode issues no memory cycle");
    end_test("count zero and invalid mode");
  endtask

  initial
  begin
    #(WD_CYCLES * CLK_NS);
    $display("Timeout: the tests did not complete within %0d clock cycles", WD_CYCLES);
    $display("Some tests failed");
    $finish;
  end

  initial
  begin
    rst_i         = 1'b1;
    wb_cyc        = 1'b0;
    wb_stb        = 1'b0;
    wb_we         = 1'b0;
    wb_adr        = '0;
    wb_dat_w      = '0;
    mem_clear     = 1'b0;
    preload_en    = 1'b0;
    preload_addr  = '0;
    ack_delay     = '0;
    fixed_delay   = '0;
    rand_delay_en = 1'b0;
    fault_en      = 1'b0;
    fault_addr    = '0;
    rand_state    = 32'hf10d;
    delay_state   = 32'hf10d;
    err_count     = 0;
    err_at_start  = 0;
    pass_tests    = 0;
    fail_tests    = 0;
    repeat (5) @(posedge clk_i);
    rst_i <= 1'b0;
    @(posedge clk_i);

    test_csr_rw();
    test_write_only();
    test_read_only();
    test_write_check();
    test_fault();
    test_edge_params();

    $display("Tests passed: %0d, tests failed: %0d, check errors: %0d",
             pass_tests, fail_tests, err_count);
    if (fail_tests == 0 && err_count == 0)
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end

endmodule : tb_mem_tester

/* verification/wb_mem_model.sv */
`timescale 1ns/1ps

module wb_mem_model (
  input  logic                clk_i,
  input  logic                rst_i,

  input  logic                clear_i,
  input  logic                preload_en_i,
  input  mem_test_pkg::addr_t preload_addr_i,
  input  logic [3:0]          ack_delay_i,
  input  logic                fault_en_i,
  input  mem_test_pkg::addr_t fault_addr_i,

  input  logic                cyc_i,
  input  logic                stb_i,
  input  logic                we_i,
  input  mem_test_pkg::addr_t adr_i,
  input  mem_test_pkg::data_t dat_i,
  output mem_test_pkg::data_t dat_o,
  output logic                ack_o
);

  import mem_test_pkg::*;

  localparam int MEM_DEPTH = 2 ** ADDR_W;
  localparam int LOG_DEPTH = 256;

  data_t      mem [0:MEM_DEPTH-1];
  logic [3:0] wait_cnt;
  int         op_cnt;
  int         wr_cnt;
  int         rd_cnt;
  logic       op_we  [0:LOG_DEPTH-1];
  addr_t      op_adr [0:LOG_DEPTH-1];

  always @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      // Fill pattern never equals the address, so stale words are caught
      for (int i = 0; i < MEM_DEPTH; i++)
        mem[i] <= {16'(i) ^ 16'ha5c3, ~16'(i)};
      ack_o    <= 1'b0;
      dat_o    <= '0;
      wait_cnt <= '0;
      op_cnt   <= 0;
      wr_cnt   <= 0;
      rd_cnt   <= 0;
    end
    else
    begin
      if (preload_en_i)
        mem[preload_addr_i] <= data_t'(preload_addr_i);
      if (clear_i)
      begin
        op_cnt <= 0;
        wr_cnt <= 0;
        rd_cnt <= 0;
      end
      if (ack_o)
        ack_o <= 1'b0;
      else if (cyc_i && stb_i)
      begin
        if (wait_cnt >= ack_delay_i)
        begin
          ack_o    <= 1'b1;
          wait_cnt <= '0;
          if (op_cnt < LOG_DEPTH)
          begin
            op_we[op_cnt]  <= we_i;
            op_adr[op_cnt] <= adr_i;
          end
          op_cnt <= op_cnt + 1;
          if (we_i)
          begin
            mem[adr_i] <= dat_i;
            wr_cnt     <= wr_cnt + 1;
          end
          else
          begin
            if (fault_en_i && (adr_i == fault_addr_i))
              dat_o <= mem[adr_i] ^ 32'h0000_0001;
            else
              dat_o <= mem[adr_i];
            rd_cnt <= rd_cnt + 1;
          end
        end
        else
          wait_cnt <= wait_cnt + 1'b1;
      end
    end
  end

endmodule : wb_mem_model

/* logic/mem_tester_top.sv */
`timescale 1ns/1ps

module mem_tester_top (
  input  logic                    clk_i,
  input  logic                    rst_i,

  input  logic                    wb_cyc_i,
  input  logic                    wb_stb_i,
  input  logic                    wb_we_i,
  input  mem_test_pkg::csr_addr_t wb_adr_i,
  input  mem_test_pkg::data_t     wb_dat_i,
  output mem_test_pkg::data_t     wb_dat_o,
  output logic                    wb_ack_o,

  output logic                    mem_cyc_o,
  output logic                    mem_stb_o,
  output logic                    mem_we_o,
  output mem_test_pkg::addr_t     mem_adr_o,
  output mem_test_pkg::data_t     mem_dat_o,
  input  mem_test_pkg::data_t     mem_dat_i,
  input  logic                    mem_ack_i
);

  import mem_test_pkg::*;

  logic      test_start;
  csr_file_t test_param;
  logic      test_finished;
  logic      test_result;
  logic      trans_valid;
  logic      trans_type;
  addr_t     trans_addr;
  logic      trans_process;
  logic      trans_busy;
  logic      rd_valid;
  addr_t     rd_addr;
  data_t     rd_data;
  logic      cmp_error;
  logic      cmp_busy;

  test_csr test_csr_inst (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .wb_cyc_i        (wb_cyc_i),
    .wb_stb_i        (wb_stb_i),
    .wb_we_i         (wb_we_i),
    .wb_adr_i        (wb_adr_i),
    .wb_dat_i        (wb_dat_i),
    .wb_dat_o        (wb_dat_o),
    .wb_ack_o        (wb_ack_o),
    .test_finished_i (test_finished),
    .test_result_i   (test_result),
    .test_start_o    (test_start),
    .test_param_o    (test_param)
  );

  control_block control_block_inst (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .test_start_i    (test_start),
    .test_param_i    (test_param),
    .test_finished_o (test_finished),
    .test_result_o   (test_result),
    .cmp_error_i     (cmp_error),
    .cmp_busy_i      (cmp_busy),
    .trans_process_i (trans_process),
    .trans_busy_i    (trans_busy),
    .trans_valid_o   (trans_valid),
    .trans_type_o    (trans_type),
    .trans_addr_o    (trans_addr)
  );

  transmitter_block transmitter_block_inst (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .trans_valid_i   (trans_valid),
    .trans_type_i    (trans_type),
    .trans_addr_i    (trans_addr),
    .trans_process_o (trans_process),
    .trans_busy_o    (trans_busy),
    .mem_cyc_o       (mem_cyc_o),
    .mem_stb_o       (mem_stb_o),
    .mem_we_o        (mem_we_o),
    .mem_adr_o       (mem_adr_o),
    .mem_dat_o       (mem_dat_o),
    .mem_dat_i       (mem_dat_i),
    .mem_ack_i       (mem_ack_i),
    .rd_valid_o      (rd_valid),
    .rd_addr_o       (rd_addr),
    .rd_data_o       (rd_data)
  );

  compare_block compare_block_inst (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .rd_valid_i  (rd_valid),
    .rd_addr_i   (rd_addr),
    .rd_data_i   (rd_data),
    .cmp_error_o (cmp_error),
    .cmp_busy_o  (cmp_busy)
  );

endmodule : mem_tester_top

/* logic/compare_block.sv */
`timescale 1ns/1ps

module compare_block (
  input  logic                clk_i,
  input  logic                rst_i,

  input  logic                rd_valid_i,
  input  mem_test_pkg::addr_t rd_addr_i,
  input  mem_test_pkg::data_t rd_data_i,

  output logic                cmp_error_o,
  output logic                cmp_busy_o
);

  import mem_test_pkg::*;

  logic  valid_q;
  addr_t rd_addr_q;
  data_t rd_data_q;

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
      valid_q <= 1'b0;
    else
      valid_q <= rd_valid_i;
  end

  always_ff @(posedge clk_i)
  begin
    if (rd_valid_i)
    begin
      rd_addr_q <= rd_addr_i;
      rd_data_q <= rd_data_i;
    end
  end

  // Expected word is the zero-extended address
  assign cmp_error_o = valid_q && (rd_data_q != data_t'(rd_addr_q));
  assign cmp_busy_o  = rd_valid_i || valid_q;

endmodule : compare_block

/* logic/transmitter_block.sv */
`timescale 1ns/1ps

module transmitter_block (
  input  logic                clk_i,
  input  logic                rst_i,

  input  logic                trans_valid_i,
  input  logic                trans_type_i,
  input  mem_test_pkg::addr_t trans_addr_i,
  output logic                trans_process_o,
  output logic                trans_busy_o,

  output logic                mem_cyc_o,
  output logic                mem_stb_o,
  output logic                mem_we_o,
  output mem_test_pkg::addr_t mem_adr_o,
  output mem_test_pkg::data_t mem_dat_o,
  input  mem_test_pkg::data_t mem_dat_i,
  input  logic                mem_ack_i,

  output logic                rd_valid_o,
  output mem_test_pkg::addr_t rd_addr_o,
  output mem_test_pkg::data_t rd_data_o
);

  import mem_test_pkg::*;

  logic  cmd_take;
  logic  cycle_q;
  logic  type_q;
  addr_t addr_q;

  assign cmd_take = trans_valid_i && !cycle_q;

  // Bus cycle opens on the edge that takes the command and closes after ack
  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
      cycle_q <= 1'b0;
    else if (cmd_take)
      cycle_q <= 1'b1;
    else if (mem_ack_i)
      cycle_q <= 1'b0;
  end

  always_ff @(posedge clk_i)
  begin
    if (cmd_take)
    begin
      type_q <= trans_type_i;
      addr_q <= trans_addr_i;
    end
  end

  assign mem_cyc_o = cycle_q;
  assign mem_stb_o = cycle_q;
  assign mem_we_o  = cycle_q && !type_q;
  assign mem_adr_o = addr_q;
  // Address-in-address pattern
  assign mem_dat_o = data_t'(addr_q);

  assign trans_process_o = cycle_q;
  assign trans_busy_o    = cycle_q || trans_valid_i;

  assign rd_valid_o = cycle_q && mem_ack_i && type_q;
  assign rd_addr_o  = addr_q;
  assign rd_data_o  = mem_dat_i;

endmodule : transmitter_block

/* logic/control_block.sv */
`timescale 1ns/1ps

module control_block (
  input  logic                    clk_i,
  input  logic                    rst_i,

  input  logic                    test_start_i,
  input  mem_test_pkg::csr_file_t test_param_i,
  output logic                    test_finished_o,
  output logic                    test_result_o,

  input  logic                    cmp_error_i,
  input  logic                    cmp_busy_i,

  input  logic                    trans_process_i,
  input  logic                    trans_busy_i,
  output logic                    trans_valid_o,
  output logic                    trans_type_o,
  output mem_test_pkg::addr_t     trans_addr_o
);

  import mem_test_pkg::*;

  typedef enum logic [2:0] {
    IDLE_S,
    LOAD_S,
    WRITE_ONLY_S,
    READ_ONLY_S,
    WRITE_WORD_S,
    READ_WORD_S,
    END_TEST_S,
    ERROR_CHECK_S
  } state_t;

  state_t     state;
  state_t     next_state;
  addr_t      next_addr;
  count_t     test_count;
  count_t     cmd_cnt;
  test_mode_t test_mode;
  logic       mode_valid;
  logic       next_addr_en;
  logic       last_cmd;
  logic       trans_valid_q;
  logic       cmd_accepted;
  logic       last_accepted;
  logic       count_state;
  logic       finish_state;
  logic       finish_flag;

  address_block address_block_inst (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .test_start_i   (test_start_i),
    .test_param_i   (test_param_i),
    .next_addr_en_i (next_addr_en),
    .next_addr_o    (next_addr)
  );

  assign test_count = test_param_i[CSR_TEST_PARAM][TEST_COUNT_MSB:TEST_COUNT_LSB];
  assign test_mode  = test_mode_t'(test_param_i[CSR_TEST_PARAM][TEST_MODE_MSB:TEST_MODE_LSB]);
  assign mode_valid = (test_mode == WRITE_ONLY) || (test_mode == READ_ONLY) ||
                      (test_mode == WRITE_AND_CHECK);

  ////////////////////////////////////////////////////////////////////////////
  // Sequencer
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
      state <= IDLE_S;
    else if (cmp_error_i)
      state <= ERROR_CHECK_S;
    else
      state <= next_state;
  end

  always_comb
  begin
    next_state = state;
    case (state)
      IDLE_S        : if (test_start_i) next_state = LOAD_S;
      LOAD_S :
      begin
        case (test_mode)
          WRITE_ONLY      : next_state = WRITE_ONLY_S;
          READ_ONLY       : next_state = READ_ONLY_S;
          WRITE_AND_CHECK : next_state = WRITE_WORD_S;
          default         : next_state = IDLE_S;
        endcase
      end
      WRITE_ONLY_S,
      READ_ONLY_S   : if (last_accepted) next_state = END_TEST_S;
      WRITE_WORD_S  : if (cmd_accepted) next_state = READ_WORD_S;
      READ_WORD_S :
      begin
        if (cmd_accepted)
          next_state = last_cmd ? END_TEST_S : WRITE_WORD_S;
      end
      END_TEST_S,
      ERROR_CHECK_S : if (finish_flag) next_state = IDLE_S;
      default       : next_state = IDLE_S;
    endcase
  end

  // Only reads are counted in write-and-check mode
  assign count_state   = (state == WRITE_ONLY_S) || (state == READ_ONLY_S) ||
                         (state == READ_WORD_S);
  assign finish_state  = (state == END_TEST_S) || (state == ERROR_CHECK_S);
  assign finish_flag   = !cmp_busy_i && !trans_busy_i;

  assign cmd_accepted  = trans_valid_o && !trans_process_i;
  assign last_accepted = last_cmd && cmd_accepted;
  assign next_addr_en  = (state == LOAD_S) || (count_state && cmd_accepted);

  ////////////////////////////////////////////////////////////////////////////
  // Command counter
  ////////////////////////////////////////////////////////////////////////////

  // A count of zero is treated as one command
  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      cmd_cnt  <= '0;
      last_cmd <= 1'b0;
    end
    else if (state == LOAD_S)
    begin
      cmd_cnt  <= test_count;
      last_cmd <= (test_count <= count_t'(1));
    end
    else if (cmd_accepted && count_state)
    begin
      cmd_cnt  <= cmd_cnt - 1'b1;
      last_cmd <= (cmd_cnt == count_t'(2));
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Command outputs and status
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
      trans_valid_q <= 1'b0;
    else if (cmp_error_i)
      trans_valid_q <= 1'b0;
    else if ((state == LOAD_S) && mode_valid)
      trans_valid_q <= 1'b1;
    else if (count_state && last_accepted)
      trans_valid_q <= 1'b0;
  end

  // A failed compare withdraws the pending command in the same cycle
  assign trans_valid_o = trans_valid_q && !cmp_error_i;

  always_ff @(posedge clk_i)
  begin
    if (state == LOAD_S)
      trans_type_o <= (test_mode == READ_ONLY);
    else if (cmd_accepted && (state == WRITE_WORD_S))
      trans_type_o <= 1'b1;
    else if (cmd_accepted && (state == READ_WORD_S))
      trans_type_o <= 1'b0;
  end

  always_ff @(posedge clk_i)
  begin
    if (next_addr_en)
      trans_addr_o <= next_addr;
  end

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      test_finished_o <= 1'b0;
      test_result_o   <= 1'b0;
    end
    else if (test_start_i)
    begin
      test_finished_o <= 1'b0;
      test_result_o   <= 1'b0;
    end
    else
    begin
      if (finish_state && finish_flag)
        test_finished_o <= 1'b1;
      if (cmp_error_i)
        test_result_o <= 1'b1;
    end
  end

endmodule : control_block

/* logic/address_block.sv */
`timescale 1ns/1ps

module address_block (
  input  logic                    clk_i,
  input  logic                    rst_i,

  input  logic                    test_start_i,
  input  mem_test_pkg::csr_file_t test_param_i,

  input  logic                    next_addr_en_i,
  output mem_test_pkg::addr_t     next_addr_o
);

  import mem_test_pkg::*;

  addr_t addr_q;
  addr_t start_addr;

  assign start_addr = test_param_i[CSR_SET_ADDR][ADDR_W-1:0];

  // Current word is presented, then the pointer moves on by one word
  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
      addr_q <= '0;
    else if (test_start_i)
      addr_q <= start_addr;
    else if (next_addr_en_i)
      addr_q <= addr_q + 1'b1;
  end

  assign next_addr_o = addr_q;

endmodule : address_block

/* logic/test_csr.sv */
`timescale 1ns/1ps

module test_csr (
  input  logic                    clk_i,
  input  logic                    rst_i,

  input  logic                    wb_cyc_i,
  input  logic                    wb_stb_i,
  input  logic                    wb_we_i,
  input  mem_test_pkg::csr_addr_t wb_adr_i,
  input  mem_test_pkg::data_t     wb_dat_i,
  output mem_test_pkg::data_t     wb_dat_o,
  output logic                    wb_ack_o,

  input  logic                    test_finished_i,
  input  logic                    test_result_i,
  output logic                    test_start_o,
  output mem_test_pkg::csr_file_t test_param_o
);

  import mem_test_pkg::*;

  logic host_req;
  logic host_wr;

  // A request is taken once; ack blocks it for the following cycle
  assign host_req = wb_cyc_i && wb_stb_i && !wb_ack_o;
  assign host_wr  = host_req && wb_we_i;

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
      wb_ack_o <= 1'b0;
    else
      wb_ack_o <= host_req;
  end

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
      test_start_o <= 1'b0;
    else
      test_start_o <= host_wr && (wb_adr_i == CSR_CTRL) && wb_dat_i[0];
  end

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
      test_param_o <= '0;
    else if (host_wr)
    begin
      case (wb_adr_i)
        CSR_TEST_PARAM : test_param_o[CSR_TEST_PARAM] <= wb_dat_i;
        CSR_SET_ADDR   : test_param_o[CSR_SET_ADDR]   <= wb_dat_i;
        default        : ;
      endcase
    end
  end

  // Read data is captured together with the ack
  always_ff @(posedge clk_i)
  begin
    if (host_req)
    begin
      case (wb_adr_i)
        CSR_CTRL       : wb_dat_o <= {{(DATA_W-2){1'b0}}, test_result_i, test_finished_i};
        CSR_TEST_PARAM : wb_dat_o <= test_param_o[CSR_TEST_PARAM];
        CSR_SET_ADDR   : wb_dat_o <= test_param_o[CSR_SET_ADDR];
        default        : wb_dat_o <= '0;
      endcase
    end
  end

endmodule : test_csr

/* logic/mem_test_pkg.sv */
package mem_test_pkg;

  localparam int ADDR_W     = 16;
  localparam int DATA_W     = 32;
  localparam int CSR_ADDR_W = 2;

  typedef logic [ADDR_W-1:0]     addr_t;
  typedef logic [DATA_W-1:0]     data_t;
  typedef logic [CSR_ADDR_W-1:0] csr_addr_t;

  // Host register map
  localparam csr_addr_t CSR_CTRL       = 2'd0;
  localparam csr_addr_t CSR_TEST_PARAM = 2'd1;
  localparam csr_addr_t CSR_SET_ADDR   = 2'd2;

  // Fields of the test parameter word
  localparam int TEST_COUNT_MSB = 31;
  localparam int TEST_COUNT_LSB = 16;
  localparam int TEST_MODE_MSB  = 15;
  localparam int TEST_MODE_LSB  = 14;

  typedef logic [TEST_COUNT_MSB-TEST_COUNT_LSB:0] count_t;

  // Encoding 3 is reserved and rejected by the sequencer
  typedef enum logic [1:0] {
    WRITE_ONLY      = 2'd0,
    READ_ONLY       = 2'd1,
    WRITE_AND_CHECK = 2'd2
  } test_mode_t;

  // Parameter registers as seen by the sequencer
  typedef data_t [CSR_SET_ADDR:CSR_TEST_PARAM] csr_file_t;

endpackage : mem_test_pkg
